/* hdl/pipePkg.sv */
// pipeline tail package with data widths, opcodes and the two instruction word views
package pipePkg;

    // data and pc width
    localparam int WORD_BITS = 32;
    // register number width, 32 architectural registers
    localparam int REG_BITS = 5;
    localparam int OP_BITS = 4;
    // immediate field of the immediate form
    localparam int IMM_BITS = 18;

    typedef logic [OP_BITS-1:0] opCode_t;

    // register form, rd = rj op rk
    localparam opCode_t OP_ADD = 4'h0;
    localparam opCode_t OP_SUB = 4'h1;
    localparam opCode_t OP_AND = 4'h2;
    localparam opCode_t OP_OR = 4'h3;
    localparam opCode_t OP_XOR = 4'h4;
    // signed compare, result is 0 or 1
    localparam opCode_t OP_SLT = 4'h5;
    // immediate form, rd = rj op imm
    localparam opCode_t OP_ADDI = 4'h8;
    localparam opCode_t OP_ORI = 4'h9;
    // rd = imm << 14, rj ignored
    localparam opCode_t OP_LUI = 4'ha;

    // one instruction word, read as either form depending on op
    typedef union packed {
        struct packed {
            opCode_t op;
            logic [REG_BITS-1:0] rd;
            logic [REG_BITS-1:0] rj;
            logic [REG_BITS-1:0] rk;
            logic [WORD_BITS-OP_BITS-3*REG_BITS-1:0] unused;
        } regForm;
        struct packed {
            opCode_t op;
            logic [REG_BITS-1:0] rd;
            logic [REG_BITS-1:0] rj;
            logic [IMM_BITS-1:0] imm;
        } immForm;
    } instrWord_u;

    // true for opcodes whose low bits carry an immediate
    function automatic logic isImmOp(opCode_t op);
        return (op == OP_ADDI) || (op == OP_ORI) || (op == OP_LUI);
    endfunction

endpackage

/* hdl/regFile.sv */
// 32-entry register file, two combinational read ports, one write port, r0 fixed at zero
`timescale 1ns/1ps
module regFile import pipePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // read side, driven from the operand-read stage
    input  logic [REG_BITS-1:0]  readNumA_i,
    input  logic [REG_BITS-1:0]  readNumB_i,
    output logic [WORD_BITS-1:0] readDataA_o,
    output logic [WORD_BITS-1:0] readDataB_o,
    // write side, driven from writeback
    input  logic                 writeEnable_i,
    input  logic [REG_BITS-1:0]  writeNum_i,
    input  logic [WORD_BITS-1:0] writeData_i
);

    localparam int NUM_REGS = 1 << REG_BITS;

    logic [WORD_BITS-1:0] regs [NUM_REGS];

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable_i && (writeNum_i != '0)) begin
            // r0 never written, so it stays zero from reset
            regs[writeNum_i] <= writeData_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // no write-through here
    // same-edge writes are covered by the writeback forward path
    assign readDataA_o = regs[readNumA_i];
    assign readDataB_o = regs[readNumB_i];

endmodule

/* hdl/operandRead.sv */
// operand-read stage: holds the issued word, decodes it, reads registers and forwards
`timescale 1ns/1ps
module operandRead import pipePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // issue port
    input  logic                 issueValid_i,
    input  logic [WORD_BITS-1:0] issueInstr_i,
    input  logic [WORD_BITS-1:0] issuePc_i,
    output logic                 issueReady_o,
    // interlock from execute
    input  logic                 exAllowin_i,
    // forward sources, execute first
    input  logic                 exFwdValid_i,
    input  logic [REG_BITS-1:0]  exFwdNum_i,
    input  logic [WORD_BITS-1:0] exFwdData_i,
    input  logic                 wbFwdValid_i,
    input  logic [REG_BITS-1:0]  wbFwdNum_i,
    input  logic [WORD_BITS-1:0] wbFwdData_i,
    // register file read
    output logic [REG_BITS-1:0]  readNumA_o,
    output logic [REG_BITS-1:0]  readNumB_o,
    input  logic [WORD_BITS-1:0] readDataA_i,
    input  logic [WORD_BITS-1:0] readDataB_i,
    // towards execute
    output logic                 rdValid_o,
    output logic [WORD_BITS-1:0] rdPc_o,
    output opCode_t              rdOp_o,
    output logic [REG_BITS-1:0]  rdDest_o,
    output logic [WORD_BITS-1:0] rdSrcA_o,
    output logic [WORD_BITS-1:0] rdSrcB_o
);

    logic                 hasData;
    instrWord_u           instrReg;
    logic [WORD_BITS-1:0] pcReg;
    opCode_t              op;
    logic [REG_BITS-1:0]  srcNumA;
    logic [REG_BITS-1:0]  srcNumB;
    logic [IMM_BITS-1:0]  imm;
    logic [WORD_BITS-1:0] extImm;
    logic [WORD_BITS-1:0] fwdA;
    logic [WORD_BITS-1:0] fwdB;

    //////////////////////////////////////////////////////////////////////
    // issue register and interlock
    //////////////////////////////////////////////////////////////////////

    // free when empty or when the current word moves on this edge
    assign issueReady_o = !hasData || exAllowin_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hasData <= 1'b0;
        end else if (issueReady_o) begin
            hasData <= issueValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issueReady_o && issueValid_i) begin
            instrReg <= issueInstr_i;
            pcReg <= issuePc_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    // op, rd and rj sit at the same place in both views
    assign op = instrReg.regForm.op;
    assign srcNumA = instrReg.regForm.rj;
    assign srcNumB = instrReg.regForm.rk;
    assign imm = instrReg.immForm.imm;

    always_comb begin
        case (op)
            OP_ORI: extImm = {{(WORD_BITS-IMM_BITS){1'b0}}, imm};
            OP_LUI: extImm = {imm, {(WORD_BITS-IMM_BITS){1'b0}}};
            // addi and anything else, sign extend
            default: extImm = {{(WORD_BITS-IMM_BITS){imm[IMM_BITS-1]}}, imm};
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // register read and forwarding
    //////////////////////////////////////////////////////////////////////

    assign readNumA_o = srcNumA;
    assign readNumB_o = srcNumB;

    // youngest producer wins: execute, then writeback, then the file
    function automatic logic [WORD_BITS-1:0] pickOperand(
        input logic [REG_BITS-1:0]  num,
        input logic [WORD_BITS-1:0] fileData
    );
        if (num == '0) begin
            return '0;
        end else if (exFwdValid_i && (exFwdNum_i == num)) begin
            return exFwdData_i;
        end else if (wbFwdValid_i && (wbFwdNum_i == num)) begin
            return wbFwdData_i;
        end
        return fileData;
    endfunction

    assign fwdA = pickOperand(srcNumA, readDataA_i);
    assign fwdB = pickOperand(srcNumB, readDataB_i);

    // hand-off to execute
    assign rdValid_o = hasData;
    assign rdPc_o = pcReg;
    assign rdOp_o = op;
    assign rdDest_o = instrReg.regForm.rd;
    assign rdSrcA_o = fwdA;
    // immediate replaces rk for the immediate form
    assign rdSrcB_o = isImmOp(op) ? extImm : fwdB;

endmodule

/* hdl/aluExecute.sv */
// execute stage: holds one instruction and computes its ALU result combinationally
`timescale 1ns/1ps
module aluExecute import pipePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // from operand read
    input  logic                 rdValid_i,
    input  logic [WORD_BITS-1:0] rdPc_i,
    input  opCode_t              rdOp_i,
    input  logic [REG_BITS-1:0]  rdDest_i,
    input  logic [WORD_BITS-1:0] rdSrcA_i,
    input  logic [WORD_BITS-1:0] rdSrcB_i,
    // interlock
    output logic                 exAllowin_o,
    input  logic                 wbAllowin_i,
    // to writeback, also the execute forward source
    output logic                 exValid_o,
    output logic [WORD_BITS-1:0] exPc_o,
    output logic [REG_BITS-1:0]  exDest_o,
    output logic [WORD_BITS-1:0] exResult_o
);

    logic                 hasData;
    logic [WORD_BITS-1:0] pcReg;
    opCode_t              opReg;
    logic [REG_BITS-1:0]  destReg;
    logic [WORD_BITS-1:0] srcAReg;
    logic [WORD_BITS-1:0] srcBReg;

    //////////////////////////////////////////////////////////////////////
    // segment register
    //////////////////////////////////////////////////////////////////////

    assign exAllowin_o = !hasData || wbAllowin_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hasData <= 1'b0;
        end else if (exAllowin_o) begin
            hasData <= rdValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exAllowin_o && rdValid_i) begin
            pcReg <= rdPc_i;
            opReg <= rdOp_i;
            destReg <= rdDest_i;
            srcAReg <= rdSrcA_i;
            srcBReg <= rdSrcB_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opReg)
            OP_ADD, OP_ADDI: exResult_o = srcAReg + srcBReg;
            OP_SUB: exResult_o = srcAReg - srcBReg;
            OP_AND: exResult_o = srcAReg & srcBReg;
            OP_OR, OP_ORI: exResult_o = srcAReg | srcBReg;
            OP_XOR: exResult_o = srcAReg ^ srcBReg;
            // signed compare, zero-filled to a word
            OP_SLT: exResult_o = {{(WORD_BITS-1){1'b0}}, $signed(srcAReg) < $signed(srcBReg)};
            // immediate already shifted in operand read
            OP_LUI: exResult_o = srcBReg;
            default: exResult_o = '0;
        endcase
    end

    assign exValid_o = hasData;
    assign exPc_o = pcReg;
    assign exDest_o = destReg;

endmodule

/* hdl/writebackStage.sv */
// writeback stage: retires into the register file, forwards, and registers the commit trace
`timescale 1ns/1ps
module writebackStage import pipePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // from execute
    input  logic                 exValid_i,
    input  logic [WORD_BITS-1:0] exPc_i,
    input  logic [REG_BITS-1:0]  exDest_i,
    input  logic [WORD_BITS-1:0] exResult_i,
    // trace consumer acts as this stage's ready
    input  logic                 traceReady_i,
    output logic                 wbAllowin_o,
    // forward valid, num and data shared with the write port
    output logic                 wbFwdValid_o,
    output logic                 wbWriteEnable_o,
    output logic [REG_BITS-1:0]  wbWriteNum_o,
    output logic [WORD_BITS-1:0] wbWriteData_o,
    // commit trace
    output logic                 commitValid_o,
    output logic [WORD_BITS-1:0] commitPc_o,
    output logic [3:0]           commitWen_o,
    output logic [REG_BITS-1:0]  commitWnum_o,
    output logic [WORD_BITS-1:0] commitWdata_o
);

    logic                 hasData;
    logic                 needUpdate;
    logic                 needClear;
    logic                 retire;
    logic [WORD_BITS-1:0] pcReg;
    logic [REG_BITS-1:0]  destReg;
    logic [WORD_BITS-1:0] dataReg;

    //////////////////////////////////////////////////////////////////////
    // interlock
    //////////////////////////////////////////////////////////////////////

    assign wbAllowin_o = !hasData || traceReady_i;
    // contents leave on this edge
    assign retire = hasData && traceReady_i;
    assign needUpdate = wbAllowin_o && exValid_i;
    // bubble arriving, segment goes back to zero
    assign needClear = wbAllowin_o && !exValid_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hasData <= 1'b0;
        end else if (wbAllowin_o) begin
            hasData <= exValid_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // segment register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst || needClear) begin
            pcReg <= '0;
            destReg <= '0;
            dataReg <= '0;
        end else if (needUpdate) begin
            pcReg <= exPc_i;
            destReg <= exDest_i;
            dataReg <= exResult_i;
        end
    end

    // held data is still the youngest copy while stalled
    assign wbFwdValid_o = hasData;
    // rd of zero means no write
    assign wbWriteEnable_o = retire && (destReg != '0);
    assign wbWriteNum_o = destReg;
    assign wbWriteData_o = dataReg;

    //////////////////////////////////////////////////////////////////////
    // commit trace
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            commitValid_o <= 1'b0;
            commitWen_o <= 4'b0;
        end else begin
            commitValid_o <= retire;
            // mask drops back to zero on idle cycles
            commitWen_o <= {4{wbWriteEnable_o}};
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commitPc_o <= pcReg;
            commitWnum_o <= destReg;
            commitWdata_o <= dataReg;
        end
    end

endmodule

/* hdl/pipeTail.sv */
// pipeline tail top: operand read, execute and writeback around one register file
`timescale 1ns/1ps
module pipeTail import pipePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // issue side
    input  logic                 issueValid_i,
    input  logic [WORD_BITS-1:0] issueInstr_i,
    input  logic [WORD_BITS-1:0] issuePc_i,
    output logic                 issueReady_o,
    // trace side
    input  logic                 traceReady_i,
    output logic                 commitValid_o,
    output logic [WORD_BITS-1:0] commitPc_o,
    output logic [3:0]           commitWen_o,
    output logic [REG_BITS-1:0]  commitWnum_o,
    output logic [WORD_BITS-1:0] commitWdata_o
);

    // register file read
    logic [REG_BITS-1:0]  readNumA;
    logic [REG_BITS-1:0]  readNumB;
    logic [WORD_BITS-1:0] readDataA;
    logic [WORD_BITS-1:0] readDataB;
    // operand read to execute
    logic                 rdValid;
    logic [WORD_BITS-1:0] rdPc;
    opCode_t              rdOp;
    logic [REG_BITS-1:0]  rdDest;
    logic [WORD_BITS-1:0] rdSrcA;
    logic [WORD_BITS-1:0] rdSrcB;
    // execute to writeback, also forwarded
    logic                 exAllowin;
    logic                 exValid;
    logic [WORD_BITS-1:0] exPc;
    logic [REG_BITS-1:0]  exDest;
    logic [WORD_BITS-1:0] exResult;
    // writeback port and forward path
    logic                 wbAllowin;
    logic                 wbFwdValid;
    logic                 wbWriteEnable;
    logic [REG_BITS-1:0]  wbWriteNum;
    logic [WORD_BITS-1:0] wbWriteData;

    regFile i_regFile (
        .clk(clk), .rst(rst),
        .readNumA_i(readNumA), .readNumB_i(readNumB),
        .readDataA_o(readDataA), .readDataB_o(readDataB),
        .writeEnable_i(wbWriteEnable), .writeNum_i(wbWriteNum), .writeData_i(wbWriteData)
    );

    operandRead i_operandRead (
        .clk(clk), .rst(rst),
        .issueValid_i(issueValid_i), .issueInstr_i(issueInstr_i),
        .issuePc_i(issuePc_i), .issueReady_o(issueReady_o),
        .exAllowin_i(exAllowin),
        .exFwdValid_i(exValid), .exFwdNum_i(exDest), .exFwdData_i(exResult),
        .wbFwdValid_i(wbFwdValid), .wbFwdNum_i(wbWriteNum), .wbFwdData_i(wbWriteData),
        .readNumA_o(readNumA), .readNumB_o(readNumB),
        .readDataA_i(readDataA), .readDataB_i(readDataB),
        .rdValid_o(rdValid), .rdPc_o(rdPc), .rdOp_o(rdOp), .rdDest_o(rdDest),
        .rdSrcA_o(rdSrcA), .rdSrcB_o(rdSrcB)
    );

    aluExecute i_aluExecute (
        .clk(clk), .rst(rst),
        .rdValid_i(rdValid), .rdPc_i(rdPc), .rdOp_i(rdOp), .rdDest_i(rdDest),
        .rdSrcA_i(rdSrcA), .rdSrcB_i(rdSrcB),
        .exAllowin_o(exAllowin), .wbAllowin_i(wbAllowin),
        .exValid_o(exValid), .exPc_o(exPc), .exDest_o(exDest), .exResult_o(exResult)
    );

    writebackStage i_writebackStage (
        .clk(clk), .rst(rst),
        .exValid_i(exValid), .exPc_i(exPc), .exDest_i(exDest), .exResult_i(exResult),
        .traceReady_i(traceReady_i), .wbAllowin_o(wbAllowin),
        .wbFwdValid_o(wbFwdValid), .wbWriteEnable_o(wbWriteEnable),
        .wbWriteNum_o(wbWriteNum), .wbWriteData_o(wbWriteData),
        .commitValid_o(commitValid_o), .commitPc_o(commitPc_o), .commitWen_o(commitWen_o),
        .commitWnum_o(commitWnum_o), .commitWdata_o(commitWdata_o)
    );

endmodule

/* dv/pipeModel.svh */
// pipeline tail reference model with architectural registers and the expected commit queue
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// architectural state, r0 never written so it stays zero
logic [31:0] archRegs [32];

// expected commits, oldest at index 0
logic [31:0] expPc [$];
logic [3:0]  expWen [$];
logic [4:0]  expWnum [$];
logic [31:0] expWdata [$];

// sequential result of one instruction word against the current registers
function automatic logic [31:0] computeResult(input logic [31:0] instr);
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [17:0] imm;
    op = instr[31:28];
    a = archRegs[instr[22:18]];
    b = archRegs[instr[17:13]];
    imm = instr[17:0];
    case (op)
        OP_ADD: return a + b;
        OP_SUB: return a - b;
        OP_AND: return a & b;
        OP_OR: return a | b;
        OP_XOR: return a ^ b;
        OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        // sign extended immediate
        OP_ADDI: return a + {{14{imm[17]}}, imm};
        // zero extended immediate
        OP_ORI: return a | {14'd0, imm};
        // upper immediate, shift by 14
        OP_LUI: return {imm, 14'd0};
        default: return 32'd0;
    endcase
endfunction

// clear registers and the expected queue
task automatic modelReset();
    for (int i = 0; i < 32; i++) begin
        archRegs[i] = '0;
    end
    expPc.delete();
    expWen.delete();
    expWnum.delete();
    expWdata.delete();
endtask

// run one accepted instruction and queue its commit
task automatic modelIssue(input logic [31:0] instr, input logic [31:0] pc);
    logic [31:0] result;
    logic [4:0]  rd;
    result = computeResult(instr);
    rd = instr[27:23];
    expPc.push_back(pc);
    expWen.push_back((rd != '0) ? 4'hf : 4'h0);
    expWnum.push_back(rd);
    expWdata.push_back(result);
    if (rd != '0) begin
        archRegs[rd] = result;
    end
endtask

`endif

/* dv/pipeTailTb.sv */
// pipeline tail testbench with random dependent instructions, back-pressure and commit checks
`timescale 1ns/1ps
module pipeTailTb import pipePkg::*; ();

    localparam int NUM_INSTR = 2000;
    localparam int CYCLE_LIMIT = 20000;
    localparam int DRAIN_LIMIT = 100;

    logic        clk;
    logic        rst;
    logic        issueValid_i;
    logic [31:0] issueInstr_i;
    logic [31:0] issuePc_i;
    logic        issueReady_o;
    logic        traceReady_i;
    logic        commitValid_o;
    logic [31:0] commitPc_o;
    logic [3:0]  commitWen_o;
    logic [4:0]  commitWnum_o;
    logic [31:0] commitWdata_o;

    // every opcode the generator draws from
    opCode_t opList [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                            OP_ADDI, OP_ORI, OP_LUI};

    `include "pipeModel.svh"

    pipeTail i_dut (
        .clk(clk), .rst(rst),
        .issueValid_i(issueValid_i), .issueInstr_i(issueInstr_i),
        .issuePc_i(issuePc_i), .issueReady_o(issueReady_o),
        .traceReady_i(traceReady_i),
        .commitValid_o(commitValid_o), .commitPc_o(commitPc_o), .commitWen_o(commitWen_o),
        .commitWnum_o(commitWnum_o), .commitWdata_o(commitWdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // mostly r0..r3 so dependencies are dense
    function automatic logic [4:0] pickReg();
        if ($urandom_range(0, 9) < 8) begin
            return 5'($urandom_range(0, 3));
        end
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] randomInstr();
        opCode_t     op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [17:0] low;
        op = opList[$urandom_range(0, 8)];
        rd = pickReg();
        rj = pickReg();
        // full random immediate, else rk plus junk in the unused bits
        if (op == OP_ADDI || op == OP_ORI || op == OP_LUI) begin
            low = 18'($urandom);
        end else begin
            low = {pickReg(), 13'($urandom)};
        end
        return {op, rd, rj, low};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // commit monitor
    //////////////////////////////////////////////////////////////////////

    // registered outputs, sampled mid-cycle
    always @(negedge clk) begin
        if (rst && commitValid_o) begin
            if (expPc.size() == 0) begin
                stopRun("a commit appeared with no instruction outstanding");
            end else begin
                assert (commitPc_o === expPc[0])
                    else reportMismatch("commitPc_o", commitPc_o, expPc[0]);
                assert (commitWen_o === expWen[0])
                    else reportMismatch("commitWen_o", 32'(commitWen_o), 32'(expWen[0]));
                assert (commitWnum_o === expWnum[0])
                    else reportMismatch("commitWnum_o", 32'(commitWnum_o), 32'(expWnum[0]));
                assert (commitWdata_o === expWdata[0])
                    else reportMismatch("commitWdata_o", commitWdata_o, expWdata[0]);
                void'(expPc.pop_front());
                void'(expWen.pop_front());
                void'(expWnum.pop_front());
                void'(expWdata.pop_front());
            end
        end else if (rst) begin
            // idle cycles carry no write mask
            assert (commitWen_o === 4'h0)
                else reportMismatch("commitWen_o", 32'(commitWen_o), 32'h0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          issued;
        int          cycles;
        logic        havePending;
        logic [31:0] pendInstr;
        logic [31:0] nextPc;

        void'($urandom(62989));
        rst = 1'b0;
        issueValid_i = 1'b0;
        issueInstr_i = '0;
        issuePc_i = '0;
        traceReady_i = 1'b0;
        modelReset();
        nextPc = 32'h1c00_0000;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        #1;
        // state right after reset
        assert (commitValid_o === 1'b0)
            else reportMismatch("commitValid_o", 32'(commitValid_o), 32'h0);
        assert (commitWen_o === 4'h0)
            else reportMismatch("commitWen_o", 32'(commitWen_o), 32'h0);
        assert (issueReady_o === 1'b1)
            else reportMismatch("issueReady_o", 32'(issueReady_o), 32'h1);

        // single lui into an empty pipe is due 3 edges after acceptance
        @(negedge clk);
        traceReady_i = 1'b1;
        issueValid_i = 1'b1;
        issueInstr_i = {OP_LUI, 5'd1, 5'd0, 18'h2_5a5b};
        issuePc_i = nextPc;
        #1;
        assert (issueReady_o === 1'b1)
            else reportMismatch("issueReady_o", 32'(issueReady_o), 32'h1);
        modelIssue(issueInstr_i, nextPc);
        nextPc += 4;
        @(posedge clk);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            issueValid_i = 1'b0;
            assert (commitValid_o === (k == 3))
                else reportMismatch("commitValid_o", 32'(commitValid_o), 32'(k == 3));
        end

        // random issue and random trace back-pressure
        issued = 0;
        cycles = 0;
        havePending = 1'b0;
        pendInstr = '0;
        while (issued < NUM_INSTR) begin
            @(negedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                stopRun("timeout: the issue phase did not accept all instructions");
            end
            if (!havePending) begin
                pendInstr = randomInstr();
                havePending = 1'b1;
            end
            traceReady_i = ($urandom_range(0, 99) < 70);
            issueValid_i = ($urandom_range(0, 99) < 75);
            issueInstr_i = pendInstr;
            issuePc_i = nextPc;
            // let ready settle before the edge
            #1;
            if (issueValid_i && issueReady_o) begin
                modelIssue(pendInstr, nextPc);
                nextPc += 4;
                issued++;
                havePending = 1'b0;
            end
        end

        // drain with the consumer always ready
        @(negedge clk);
        issueValid_i = 1'b0;
        traceReady_i = 1'b1;
        cycles = 0;
        while (expPc.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end

        if (expPc.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stopRun("timeout: expected commits still outstanding after the drain");
        end
    end

endmodule

/* build.f */
+incdir+dv
hdl/pipePkg.sv
hdl/regFile.sv
hdl/operandRead.sv
hdl/aluExecute.sv
hdl/writebackStage.sv
hdl/pipeTail.sv
dv/pipeTailTb.sv

/* run.sh */
#!/bin/sh
# build the pipeline tail testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module pipeTailTb -f build.f -o pipeTailSim

# the log decides the result, so a fatal exit must not stop the script here
./obj_dir/pipeTailSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0
